// ==== verilog/rename_macros.svh ====
// sizes are fixed together: the free list depth must equal physical tags minus arch registers
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// register counts
`define RN_ARCH_REGS 32
`define RN_PHYS_REGS 64

// reorder buffer lines, a power of two so pointers wrap by themselves
`define RN_ROB_DEPTH 16

// data and opaque instruction body
`define RN_XLEN 64
`define RN_PAYLOAD_BITS 32

// index widths
`define RN_ARCH_BITS 5
`define RN_TAG_BITS 6
`define RN_LINE_BITS 4

// spare tags beyond the architectural ones
`define RN_FREE_DEPTH (`RN_PHYS_REGS - `RN_ARCH_REGS)

`endif

// ==== verilog/rn_port_pkg.sv ====
// records seen at the rename unit boundary; the payload is opaque and never decoded here
`default_nettype none

`include "rename_macros.svh"

package rn_port_pkg;

    typedef logic [`RN_ARCH_BITS-1:0] arch_addr_t;
    typedef logic [`RN_TAG_BITS-1:0] phys_tag_t;
    typedef logic [`RN_XLEN-1:0] xlen_t;
    typedef logic [`RN_PAYLOAD_BITS-1:0] payload_t;

    // decoded instruction entering rename
    typedef struct packed {
        logic uses_rs1;
        logic uses_rs2;
        logic uses_rd;
        arch_addr_t rs1;
        arch_addr_t rs2;
        arch_addr_t rd;
        payload_t payload;
    } dispatch_t;

    // operands handed to the function unit
    typedef struct packed {
        logic [`RN_LINE_BITS-1:0] line;
        phys_tag_t prd;
        xlen_t rs1_data;
        xlen_t rs2_data;
        payload_t payload;
    } issue_t;

    typedef struct packed {
        logic valid;
        logic [`RN_LINE_BITS-1:0] line;
        phys_tag_t prd;
        xlen_t data;
    } writeback_t;

    // retired instruction, rd is zero when there is no destination
    typedef struct packed {
        arch_addr_t rd;
        phys_tag_t prd;
        phys_tag_t lprd;
        payload_t payload;
    } commit_t;

endpackage

`default_nettype wire

// ==== verilog/rn_rob_pkg.sv ====
// reorder bookkeeping types; internal to the unit, not seen on its ports
`default_nettype none

`include "rename_macros.svh"

package rn_rob_pkg;

    import rn_port_pkg::*;

    typedef logic [`RN_LINE_BITS-1:0] rob_line_t;

    // one reorder line as written at dispatch
    typedef struct packed {
        phys_tag_t prs1;
        phys_tag_t prs2;
        phys_tag_t prd;
        phys_tag_t lprd;
        arch_addr_t rd;
        logic has_rd;
        payload_t payload;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== verilog/free_list.sv ====
// free tag FIFO; never holds more than RN_FREE_DEPTH tags, and releasing tag 0 is ignored
`timescale 1ns/1ps

`include "rename_macros.svh"

`default_nettype none

module free_list (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   alloc,
    output rn_port_pkg::phys_tag_t alloc_tag,
    output logic                  empty,
    input  wire                   release_valid,
    input  rn_port_pkg::phys_tag_t release_tag,
    input  wire                   commit_take,
    input  wire                   flush
);

    import rn_port_pkg::*;

    // extra msb tells full from empty
    localparam int PTR_BITS = $clog2(`RN_FREE_DEPTH) + 1;

    phys_tag_t store [`RN_FREE_DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    // read pointer as seen by retired instructions only
    logic [PTR_BITS-1:0] cmt_rd_ptr;
    logic do_release;

    assign do_release = release_valid && (release_tag != '0);
    assign empty = (rd_ptr == wr_ptr);
    assign alloc_tag = store[rd_ptr[PTR_BITS-2:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
                store[i] <= phys_tag_t'(`RN_ARCH_REGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= PTR_BITS'(`RN_FREE_DEPTH);
            cmt_rd_ptr <= '0;
        end else begin
            if (do_release) begin
                store[wr_ptr[PTR_BITS-2:0]] <= release_tag;
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (commit_take) begin
                cmt_rd_ptr <= cmt_rd_ptr + 1'b1;
            end
            // in-flight tags sit between cmt_rd_ptr and rd_ptr
            if (flush) begin
                rd_ptr <= cmt_rd_ptr;
            end else if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_map.sv ====
// x0 is never renamed; a destination of x0 or an unused rd takes no tag
`timescale 1ns/1ps

`include "rename_macros.svh"

`default_nettype none

module rename_map (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    accept,
    input  rn_port_pkg::dispatch_t  dispatch,
    input  rn_port_pkg::phys_tag_t  alloc_tag,
    output logic                   needs_tag,
    output rn_rob_pkg::rob_entry_t  entry,
    input  wire                    commit_valid,
    input  rn_port_pkg::commit_t    commit,
    input  wire                    flush
);

    import rn_port_pkg::*;

    phys_tag_t spec_map [`RN_ARCH_REGS];
    // map as of the last retired instruction
    phys_tag_t cmt_map [`RN_ARCH_REGS];
    logic has_rd;

    assign has_rd = dispatch.uses_rd && (dispatch.rd != '0);
    assign needs_tag = accept && has_rd && !flush;

    // unused sources read tag 0, always ready
    assign entry.prs1 = dispatch.uses_rs1 ? spec_map[dispatch.rs1] : '0;
    assign entry.prs2 = dispatch.uses_rs2 ? spec_map[dispatch.rs2] : '0;
    assign entry.prd = has_rd ? alloc_tag : '0;
    assign entry.lprd = has_rd ? spec_map[dispatch.rd] : '0;
    assign entry.rd = has_rd ? dispatch.rd : '0;
    assign entry.has_rd = has_rd;
    assign entry.payload = dispatch.payload;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_map[i] <= phys_tag_t'(i);
            end
        end else if (flush) begin
            spec_map <= cmt_map;
        end else if (needs_tag) begin
            spec_map[dispatch.rd] <= alloc_tag;
        end
    end

    // commit_valid is already low in a flush cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                cmt_map[i] <= phys_tag_t'(i);
            end
        end else if (commit_valid && (commit.rd != '0)) begin
            cmt_map[commit.rd] <= commit.prd;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/phys_regfile.sv ====
// reads are combinational with no writeback bypass; tag 0 reads as zero and ready
`timescale 1ns/1ps

`include "rename_macros.svh"

`default_nettype none

module phys_regfile (
    input  wire                      clk,
    input  wire                      reset,
    input  rn_port_pkg::phys_tag_t    rs1_tag,
    input  rn_port_pkg::phys_tag_t    rs2_tag,
    output rn_port_pkg::xlen_t        rs1_data,
    output rn_port_pkg::xlen_t        rs2_data,
    output logic                     rs1_ready,
    output logic                     rs2_ready,
    input  rn_port_pkg::phys_tag_t    clear_tag,
    input  wire                      clear_valid,
    input  rn_port_pkg::writeback_t   wb
);

    import rn_port_pkg::*;

    xlen_t data_q [`RN_PHYS_REGS];
    logic [`RN_PHYS_REGS-1:0] ready_q;

    assign rs1_data = (rs1_tag == '0) ? '0 : data_q[rs1_tag];
    assign rs2_data = (rs2_tag == '0) ? '0 : data_q[rs2_tag];
    assign rs1_ready = (rs1_tag == '0) || ready_q[rs1_tag];
    assign rs2_ready = (rs2_tag == '0) || ready_q[rs2_tag];

    // architectural state starts at zero, every tag ready
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RN_PHYS_REGS; i++) begin
                data_q[i] <= '0;
            end
            ready_q <= '1;
        end else begin
            if (wb.valid && (wb.prd != '0)) begin
                data_q[wb.prd] <= wb.data;
                ready_q[wb.prd] <= 1'b1;
            end
            if (clear_valid && (clear_tag != '0)) begin
                ready_q[clear_tag] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reorder_buffer.sv ====
// in-order issue and commit; a writeback must name a live, issued line
`timescale 1ns/1ps

`include "rename_macros.svh"

`default_nettype none

module reorder_buffer (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      accept,
    input  rn_rob_pkg::rob_entry_t    entry,
    output logic                     rob_ready,
    input  wire                      free_empty,
    output logic                     issue_valid,
    output rn_port_pkg::issue_t       issue,
    input  wire                      fu_ready,
    output rn_port_pkg::phys_tag_t    rs1_tag,
    output rn_port_pkg::phys_tag_t    rs2_tag,
    input  rn_port_pkg::xlen_t        rs1_data,
    input  rn_port_pkg::xlen_t        rs2_data,
    input  wire                      rs1_ready,
    input  wire                      rs2_ready,
    input  rn_port_pkg::writeback_t   wb,
    output logic                     commit_valid,
    output rn_port_pkg::commit_t      commit,
    output logic                     commit_take,
    input  wire                      flush
);

    import rn_rob_pkg::*;

    rob_entry_t entries [`RN_ROB_DEPTH];
    logic [`RN_ROB_DEPTH-1:0] used_q;
    logic [`RN_ROB_DEPTH-1:0] issued_q;
    logic [`RN_ROB_DEPTH-1:0] finished_q;

    rob_line_t alloc_ptr;
    rob_line_t issue_ptr;
    rob_line_t commit_ptr;

    rob_entry_t iss_entry;
    rob_entry_t cm_entry;
    logic issue_fire;

    assign iss_entry = entries[issue_ptr];
    assign cm_entry = entries[commit_ptr];

    // dispatch side, independent of what is being dispatched
    assign rob_ready = !used_q[alloc_ptr] && !free_empty;

    // operand lookup for the line waiting to issue
    assign rs1_tag = iss_entry.prs1;
    assign rs2_tag = iss_entry.prs2;

    assign issue_valid = used_q[issue_ptr] && !issued_q[issue_ptr]
                         && rs1_ready && rs2_ready && !flush;
    assign issue_fire = issue_valid && fu_ready;

    assign issue.line = issue_ptr;
    assign issue.prd = iss_entry.prd;
    assign issue.rs1_data = rs1_data;
    assign issue.rs2_data = rs2_data;
    assign issue.payload = iss_entry.payload;

    // flush wins over a finished head
    assign commit_valid = used_q[commit_ptr] && finished_q[commit_ptr] && !flush;
    assign commit_take = commit_valid && cm_entry.has_rd;

    assign commit.rd = cm_entry.rd;
    assign commit.prd = cm_entry.prd;
    assign commit.lprd = cm_entry.lprd;
    assign commit.payload = cm_entry.payload;

    always_ff @(posedge clk) begin
        if (accept) begin
            entries[alloc_ptr] <= entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            used_q <= '0;
            issued_q <= '0;
            finished_q <= '0;
            alloc_ptr <= '0;
            issue_ptr <= '0;
            commit_ptr <= '0;
        end else begin
            if (wb.valid) begin
                finished_q[wb.line] <= 1'b1;
            end
            if (accept) begin
                used_q[alloc_ptr] <= 1'b1;
                issued_q[alloc_ptr] <= 1'b0;
                finished_q[alloc_ptr] <= 1'b0;
                alloc_ptr <= alloc_ptr + 1'b1;
            end
            if (issue_fire) begin
                issued_q[issue_ptr] <= 1'b1;
                issue_ptr <= issue_ptr + 1'b1;
            end
            // head line frees, tag release happens in the free list
            if (commit_valid) begin
                used_q[commit_ptr] <= 1'b0;
                commit_ptr <= commit_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_unit.sv ====
// one dispatch, one issue, one writeback and one commit per cycle; flush drops all in-flight lines
`timescale 1ns/1ps

`default_nettype none

module rename_unit (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      dispatch_valid,
    input  rn_port_pkg::dispatch_t    dispatch,
    output logic                     rob_ready,
    output logic                     issue_valid,
    output rn_port_pkg::issue_t       issue,
    input  wire                      fu_ready,
    input  rn_port_pkg::writeback_t   wb,
    output logic                     commit_valid,
    output rn_port_pkg::commit_t      commit,
    input  wire                      flush
);

    import rn_port_pkg::*;
    import rn_rob_pkg::*;

    logic accept;
    logic needs_tag;
    logic free_empty;
    logic commit_take;
    logic rs1_ready;
    logic rs2_ready;
    phys_tag_t alloc_tag;
    phys_tag_t rs1_tag;
    phys_tag_t rs2_tag;
    xlen_t rs1_data;
    xlen_t rs2_data;
    rob_entry_t entry;

    assign accept = dispatch_valid && rob_ready;

    free_list u_free_list (
        .clk           (clk),
        .reset         (reset),
        .alloc         (needs_tag),
        .alloc_tag     (alloc_tag),
        .empty         (free_empty),
        .release_valid (commit_valid),
        .release_tag   (commit.lprd),
        .commit_take   (commit_take),
        .flush         (flush)
    );

    rename_map u_rename_map (
        .clk          (clk),
        .reset        (reset),
        .accept       (accept),
        .dispatch     (dispatch),
        .alloc_tag    (alloc_tag),
        .needs_tag    (needs_tag),
        .entry        (entry),
        .commit_valid (commit_valid),
        .commit       (commit),
        .flush        (flush)
    );

    // new destination tag goes not-ready on the accept edge
    phys_regfile u_phys_regfile (
        .clk         (clk),
        .reset       (reset),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_ready   (rs1_ready),
        .rs2_ready   (rs2_ready),
        .clear_tag   (alloc_tag),
        .clear_valid (needs_tag),
        .wb          (wb)
    );

    reorder_buffer u_reorder_buffer (
        .clk          (clk),
        .reset        (reset),
        .accept       (accept),
        .entry        (entry),
        .rob_ready    (rob_ready),
        .free_empty   (free_empty),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .fu_ready     (fu_ready),
        .rs1_tag      (rs1_tag),
        .rs2_tag      (rs2_tag),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_ready    (rs1_ready),
        .rs2_ready    (rs2_ready),
        .wb           (wb),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_take  (commit_take),
        .flush        (flush)
    );

endmodule

`default_nettype wire

// ==== bench/rename_properties.sv ====
// bound to rename_unit; reaches into the free list instance for its write pointer
`timescale 1ns/1ps

`include "rename_macros.svh"

`default_nettype none

module rename_properties (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           flush,
    input  wire                           issue_valid,
    input  wire                           commit_valid,
    input  rn_port_pkg::phys_tag_t         commit_lprd,
    input  wire [$clog2(`RN_FREE_DEPTH):0] free_wr_ptr
);

    import rn_port_pkg::*;

    int fail_count = 0;

    // nothing can be finished right out of reset
    assert property (@(posedge clk) $fell(reset) |-> !commit_valid)
        else begin
            fail_count++;
            $error("commit_valid high in the first cycle after reset");
        end

    // all lines are gone once the flush edge has passed
    assert property (@(posedge clk) disable iff (reset) flush |=> !issue_valid)
        else begin
            fail_count++;
            $error("issue_valid high in the cycle after a flush");
        end

    // tag 0 never goes back to the free list
    assert property (@(posedge clk) disable iff (reset)
                     (commit_valid && commit_lprd == '0) |=> $stable(free_wr_ptr))
        else begin
            fail_count++;
            $error("free list written for a commit with lprd tag 0");
        end

endmodule

bind rename_unit rename_properties props (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .issue_valid  (issue_valid),
    .commit_valid (commit_valid),
    .commit_lprd  (commit.lprd),
    .free_wr_ptr  (u_free_list.wr_ptr)
);

`default_nettype wire

// ==== bench/rename_checker.sv ====
// reference model of maps, free list and values; assumes writebacks return rs1 + rs2 + payload
`timescale 1ns/1ps

`include "rename_macros.svh"

`default_nettype none

module rename_checker (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      dispatch_valid,
    input  rn_port_pkg::dispatch_t    dispatch,
    input  wire                      rob_ready,
    input  wire                      issue_valid,
    input  rn_port_pkg::issue_t       issue,
    input  wire                      fu_ready,
    input  wire                      commit_valid,
    input  rn_port_pkg::commit_t      commit,
    input  wire                      flush,
    output int                       errors,
    output int                       committed,
    output int                       flushed
);

    import rn_port_pkg::*;

    // one in-flight instruction as the model sees it
    typedef struct packed {
        logic [15:0] test;
        logic bad;
        logic [`RN_LINE_BITS-1:0] line;
        arch_addr_t rd;
        phys_tag_t prd;
        phys_tag_t lprd;
        xlen_t r1;
        xlen_t r2;
        xlen_t result;
        payload_t payload;
    } line_t;

    phys_tag_t spec_map [`RN_ARCH_REGS];
    phys_tag_t cmt_map [`RN_ARCH_REGS];
    xlen_t spec_val [`RN_ARCH_REGS];
    xlen_t cmt_val [`RN_ARCH_REGS];
    phys_tag_t free_q [$];
    // tags taken by lines not yet committed, oldest first
    phys_tag_t taken_q [$];
    line_t fly_q [$];
    int issue_cnt;
    int tests;
    // lines fill in program order from zero
    logic [`RN_LINE_BITS-1:0] next_line;
    logic held;
    issue_t held_issue;

    function automatic bit differs(string name, logic [63:0] exp, logic [63:0] got);
        if (exp !== got) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    always @(posedge clk) begin
        line_t ln;
        if (reset) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_map[i] = phys_tag_t'(i);
                cmt_map[i] = phys_tag_t'(i);
                spec_val[i] = '0;
                cmt_val[i] = '0;
            end
            free_q.delete();
            taken_q.delete();
            fly_q.delete();
            for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
                free_q.push_back(phys_tag_t'(`RN_ARCH_REGS + i));
            end
            issue_cnt = 0;
            tests = 0;
            next_line = '0;
            held = 1'b0;
            errors = 0;
            committed = 0;
            flushed = 0;
        end else begin
            // a stalled issue must not move
            if (held && !flush) begin
                void'(differs("issue_valid", 64'd1, 64'(issue_valid)));
                if (issue !== held_issue) begin
                    errors++;
                    $display("Mismatch at %0t: issue expected %h got %h",
                             $time, held_issue, issue);
                end
            end
            held = issue_valid && !fu_ready;
            held_issue = issue;
            void'(differs("rob_ready",
                          64'(fly_q.size() < `RN_ROB_DEPTH && free_q.size() > 0),
                          64'(rob_ready)));
            if (flush) begin
                foreach (fly_q[i]) begin
                    $display("test %0d flushed", fly_q[i].test);
                    flushed++;
                end
                // reclaimed tags come back ahead of the older free ones
                free_q = {taken_q, free_q};
                taken_q.delete();
                fly_q.delete();
                issue_cnt = 0;
                next_line = '0;
                spec_map = cmt_map;
                spec_val = cmt_val;
            end else begin
                if (issue_valid && fu_ready) begin
                    if (issue_cnt >= fly_q.size()) begin
                        errors++;
                        $display("issue at %0t with no line waiting", $time);
                    end else begin
                        ln = fly_q[issue_cnt];
                        ln.bad |= differs("issue.line", 64'(ln.line), 64'(issue.line));
                        ln.bad |= differs("issue.prd", 64'(ln.prd), 64'(issue.prd));
                        ln.bad |= differs("issue.rs1_data", ln.r1, issue.rs1_data);
                        ln.bad |= differs("issue.rs2_data", ln.r2, issue.rs2_data);
                        ln.bad |= differs("issue.payload", 64'(ln.payload), 64'(issue.payload));
                        fly_q[issue_cnt] = ln;
                        issue_cnt++;
                    end
                end
                if (commit_valid) begin
                    if (fly_q.size() == 0) begin
                        errors++;
                        $display("commit at %0t with no line in flight", $time);
                    end else begin
                        ln = fly_q.pop_front();
                        issue_cnt--;
                        ln.bad |= differs("commit.rd", 64'(ln.rd), 64'(commit.rd));
                        ln.bad |= differs("commit.prd", 64'(ln.prd), 64'(commit.prd));
                        ln.bad |= differs("commit.lprd", 64'(ln.lprd), 64'(commit.lprd));
                        ln.bad |= differs("commit.payload", 64'(ln.payload),
                                          64'(commit.payload));
                        if (ln.rd != '0) begin
                            cmt_map[ln.rd] = ln.prd;
                            cmt_val[ln.rd] = ln.result;
                            void'(taken_q.pop_front());
                        end
                        if (ln.lprd != '0) begin
                            free_q.push_back(ln.lprd);
                        end
                        committed++;
                        $display("test %0d committed %s", ln.test, ln.bad ? "with errors" : "ok");
                    end
                end
                if (dispatch_valid && rob_ready) begin
                    ln = '0;
                    ln.test = 16'(tests);
                    tests++;
                    ln.line = next_line;
                    next_line = next_line + 1'b1;
                    ln.payload = dispatch.payload;
                    ln.r1 = dispatch.uses_rs1 ? spec_val[dispatch.rs1] : '0;
                    ln.r2 = dispatch.uses_rs2 ? spec_val[dispatch.rs2] : '0;
                    ln.result = ln.r1 + ln.r2 + xlen_t'(dispatch.payload);
                    if (dispatch.uses_rd && dispatch.rd != '0) begin
                        ln.rd = dispatch.rd;
                        ln.prd = free_q.pop_front();
                        ln.lprd = spec_map[dispatch.rd];
                        taken_q.push_back(ln.prd);
                        spec_map[dispatch.rd] = ln.prd;
                        spec_val[dispatch.rd] = ln.result;
                    end
                    fly_q.push_back(ln);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/rename_unit_tb.sv ====
// single-clock testbench; writebacks return in issue order and are dropped by a flush
`timescale 1ns/1ps

`include "rename_macros.svh"

`default_nettype none

module rename_unit_tb;

    import rn_port_pkg::*;

    localparam int NUM_ROWS = 56;
    localparam int CYCLES_PER_ROW = 60;
    localparam int PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    localparam int LIMIT_NS = (NUM_ROWS * CYCLES_PER_ROW + RESET_CYCLES) * PERIOD;

    typedef struct packed {
        arch_addr_t rd;
        arch_addr_t rs1;
        arch_addr_t rs2;
        logic use1;
        logic use2;
        logic used;
        payload_t payload;
        logic [7:0] hold;
        logic flush_after;
    } row_t;

    // pending result for the responder
    typedef struct packed {
        logic [`RN_LINE_BITS-1:0] line;
        phys_tag_t prd;
        xlen_t data;
        logic [7:0] delay;
    } job_t;

    logic clk;
    logic reset;
    logic dispatch_valid;
    dispatch_t dispatch;
    logic rob_ready;
    logic issue_valid;
    issue_t issue;
    logic fu_ready;
    writeback_t wb;
    logic commit_valid;
    commit_t commit;
    logic flush;
    int errors;
    int committed;
    int flushed;

    row_t rows [NUM_ROWS];
    job_t pend_q [$];
    int seed = 41887;

    rename_unit dut (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .rob_ready      (rob_ready),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .fu_ready       (fu_ready),
        .wb             (wb),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .flush          (flush)
    );

    rename_checker checks (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .rob_ready      (rob_ready),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .fu_ready       (fu_ready),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .flush          (flush),
        .errors         (errors),
        .committed      (committed),
        .flushed        (flushed)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // first rows form a short dependent chain, the rest chain through the previous rd
    function automatic row_t make_row(int i);
        row_t r;
        r = '0;
        r.use1 = 1'b1;
        r.used = 1'b1;
        r.payload = 32'h0100_0000 + 32'(i * 17);
        case (i)
            0: r.use1 = 1'b0;
            1: r.rs1 = 5'd1;
            2: r.rs1 = 5'd2;
            3: begin
                r.rs1 = 5'd2;
                r.rs2 = 5'd1;
                r.use2 = 1'b1;
            end
            default: begin
                r.rs1 = 5'(((i - 1) * 7) % 31 + 1);
                r.rs2 = 5'((i * 3) % 32);
                r.use2 = (i % 4 != 0);
            end
        endcase
        case (i)
            0: r.rd = 5'd1;
            1: r.rd = 5'd2;
            2: r.rd = 5'd0;
            3: r.rd = 5'd3;
            default: r.rd = (i % 9 == 0) ? 5'd0 : 5'((i * 7) % 31 + 1);
        endcase
        // short stall, then a long one that fills the reorder buffer
        r.hold = (i == 10) ? 8'd6 : (i == 20) ? 8'd60 : 8'd0;
        r.flush_after = (i == 14 || i == 40);
        return r;
    endfunction

    initial begin
        #(LIMIT_NS);
        $display("timeout: the run did not finish within %0d ns", LIMIT_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int idx;
        int outstanding;
        int hold_left;
        int failures;
        bit flush_due;
        bit done;
        job_t job;
        writeback_t wb_next;
        for (int i = 0; i < NUM_ROWS; i++) begin
            rows[i] = make_row(i);
        end
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch = '0;
        fu_ready = 1'b1;
        wb = '0;
        flush = 1'b0;
        idx = 0;
        outstanding = 0;
        hold_left = 0;
        flush_due = 1'b0;
        done = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (!done) begin
            @(posedge clk);
            // what the DUT took on this edge
            if (!reset && flush) begin
                pend_q.delete();
                outstanding = 0;
            end else if (!reset) begin
                if (dispatch_valid && rob_ready) begin
                    outstanding++;
                    flush_due = rows[idx].flush_after;
                    if (rows[idx].hold != '0) begin
                        hold_left = int'(rows[idx].hold);
                    end
                    idx++;
                end
                if (commit_valid) begin
                    outstanding--;
                end
                if (issue_valid && fu_ready) begin
                    job.line = issue.line;
                    job.prd = issue.prd;
                    job.data = issue.rs1_data + issue.rs2_data + xlen_t'(issue.payload);
                    job.delay = 8'($unsigned($random(seed)) % 4);
                    pend_q.push_back(job);
                end
            end
            wb_next = '0;
            if (flush_due) begin
                flush <= 1'b1;
                dispatch_valid <= 1'b0;
                flush_due = 1'b0;
            end else begin
                flush <= 1'b0;
                if (pend_q.size() > 0) begin
                    job = pend_q[0];
                    if (job.delay == '0) begin
                        wb_next.valid = 1'b1;
                        wb_next.line = job.line;
                        wb_next.prd = job.prd;
                        wb_next.data = job.data;
                        void'(pend_q.pop_front());
                    end else begin
                        job.delay = job.delay - 8'd1;
                        pend_q[0] = job;
                    end
                end
                if (idx < NUM_ROWS) begin
                    dispatch_valid <= 1'b1;
                    dispatch <= '{uses_rs1: rows[idx].use1, uses_rs2: rows[idx].use2,
                                  uses_rd: rows[idx].used, rs1: rows[idx].rs1,
                                  rs2: rows[idx].rs2, rd: rows[idx].rd,
                                  payload: rows[idx].payload};
                end else begin
                    dispatch_valid <= 1'b0;
                end
            end
            wb <= wb_next;
            fu_ready <= (hold_left == 0);
            if (hold_left > 0) begin
                hold_left--;
            end
            done = (idx == NUM_ROWS) && (outstanding == 0) && (pend_q.size() == 0)
                   && !flush_due && !flush;
        end
        repeat (2) @(posedge clk);
        // assertion failures count as errors too
        failures = errors + dut.props.fail_count;
        $display("tests %0d, committed %0d, flushed %0d, errors %0d",
                 NUM_ROWS, committed, flushed, failures);
        if (committed + flushed != NUM_ROWS) begin
            $display("only %0d of %0d tests retired or flushed", committed + flushed, NUM_ROWS);
        end
        if (failures == 0 && committed + flushed == NUM_ROWS) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_unit.f ====
+incdir+verilog
verilog/rn_port_pkg.sv
verilog/rn_rob_pkg.sv
verilog/free_list.sv
verilog/rename_map.sv
verilog/phys_regfile.sv
verilog/reorder_buffer.sv
verilog/rename_unit.sv
bench/rename_properties.sv
bench/rename_checker.sv
bench/rename_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rename unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rename_unit.f --top-module rename_unit_tb -o rename_sim

./obj_dir/rename_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log || ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
